// File: common/bp_pkg.sv
/* shared widths, reset values and payload types of the branch prediction unit
   imported by every RTL module and by the testbench */
package bp_pkg;

    // data and address width
    localparam int xlen = 32;

    // direct-mapped table size, power of two
    localparam int btb_entries = 64;
    // index is pc[btb_index_w+1:2]
    localparam int btb_index_w = 6;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;
    // no real pc ever has all ones, marks an empty slot
    localparam logic [xlen-1:0] invalid_tag = '1;

    // credits toward instruction memory
    localparam int fetch_credits = 4;
    // queue slots, also the credits execute starts with
    localparam int update_depth = 4;

    // bimodal counter, 0/1 not taken, 2/3 taken
    typedef logic [1:0] counter_t;

    // one fetch request toward instruction memory
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pred_next_pc;
    } fetch_req_t;

    // resolved outcome coming back from execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        // 0 means the instruction at pc is not a branch
        logic            is_br;
        logic            taken;
        // only meaningful when taken
        logic [xlen-1:0] target;
    } bp_update_t;

endpackage

// File: src/predictor/two_bit_counter.sv
/* direct-mapped btb with bimodal counters, gives next_pc for the fetch pc
   combinationally and trains from resolved branches one cycle after they arrive */
`timescale 1ns/1ns

module two_bit_counter (
    input  logic                    clk,
    input  logic                    arst_n,
    // address being fetched this cycle
    input  logic [bp_pkg::xlen-1:0] pc,
    output logic [bp_pkg::xlen-1:0] next_pc,
    // resolved outcome from the update queue
    input  logic                    upd_valid,
    input  bp_pkg::bp_update_t      upd
);

    import bp_pkg::*;

    // full pc kept as tag, invalid_tag when empty
    logic [xlen-1:0] tags    [btb_entries];
    // target used when the counter says taken
    logic [xlen-1:0] targets [btb_entries];
    counter_t        counters[btb_entries];

    // update held one cycle before it hits the table
    logic       upd_q_valid;
    bp_update_t upd_q;

    logic [btb_index_w-1:0] rd_idx;
    logic [btb_index_w-1:0] wr_idx;
    counter_t               cnt_cur;
    counter_t               cnt_next;
    logic                   hit;

    // low two bits are always zero without compressed instructions
    assign rd_idx = pc[btb_index_w+1:2];
    assign wr_idx = upd_q.pc[btb_index_w+1:2];

    // lookup
    // tag must match the whole pc, otherwise an aliasing pc would steal the target
    assign hit     = (tags[rd_idx] == pc);
    assign next_pc = (hit && counters[rd_idx][1]) ? targets[rd_idx] : pc + xlen'(4);

    // saturating step toward the resolved direction
    assign cnt_cur = counters[wr_idx];

    always_comb begin
        cnt_next = cnt_cur;
        if (upd_q.taken) begin
            if (cnt_cur != 2'd3) begin
                cnt_next = cnt_cur + 2'd1;
            end
        end else begin
            if (cnt_cur != 2'd0) begin
                cnt_next = cnt_cur - 2'd1;
            end
        end
    end

    // capture stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_q_valid <= 1'b0;
            upd_q       <= '0;
        end else begin
            upd_q_valid <= upd_valid;
            upd_q       <= upd;
        end
    end

    // table write, visible to lookups the cycle after
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_entries; i++) begin
                tags[i]     <= invalid_tag;
                targets[i]  <= '0;
                counters[i] <= 2'd0;
            end
        end else if (upd_q_valid) begin
            if (!upd_q.is_br) begin
                // not a branch at this pc, drop the entry
                tags[wr_idx]     <= invalid_tag;
                counters[wr_idx] <= 2'd0;
            end else begin
                tags[wr_idx]     <= upd_q.pc;
                // keep the old target on not taken
                if (upd_q.taken) begin
                    targets[wr_idx] <= upd_q.target;
                end
                counters[wr_idx] <= cnt_next;
            end
        end
    end

endmodule

// File: src/fetch_pc_gen.sv
/* fetch pc register with redirect and credit counting toward instruction memory
   issues one request per cycle while credits remain */
`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    arst_n,
    // prediction for the current pc
    input  logic [bp_pkg::xlen-1:0] pred_next_pc,
    // misprediction override from execute
    input  logic                    redirect_valid,
    input  logic [bp_pkg::xlen-1:0] redirect_pc,
    // one credit back from memory per pulse
    input  logic                    fetch_credit,
    output logic [bp_pkg::xlen-1:0] pc,
    output logic                    fetch_valid,
    output bp_pkg::fetch_req_t      fetch_req
);

    import bp_pkg::*;

    localparam int credit_w = $clog2(fetch_credits + 1);

    logic [credit_w-1:0] credits;
    // low for the first cycle after reset release
    logic                active;

    // a request goes out whenever a credit is held
    assign fetch_valid = active && (credits != '0);

    assign fetch_req.pc           = pc;
    assign fetch_req.pred_next_pc = pred_next_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // pc, redirect takes priority over the prediction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (fetch_valid) begin
            pc <= pred_next_pc;
        end
    end

    // return and send may land in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_w'(fetch_credits);
        end else begin
            credits <= credits + credit_w'(fetch_credit) - credit_w'(fetch_valid);
        end
    end

endmodule

// File: src/update_queue.sv
/* credit-based fifo between execute and the predictor, pops its head every cycle
   it holds an entry and returns one credit to the sender per pop */
`timescale 1ns/1ns

module update_queue #(
    parameter type payload_t = bp_pkg::bp_update_t
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     pop_valid,
    output payload_t pop_data,
    // pulse, one credit back to the sender
    output logic     credit_return
);

    import bp_pkg::*;

    localparam int ptr_w = $clog2(update_depth);
    localparam int cnt_w = $clog2(update_depth + 1);

    payload_t           mem[update_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               pop;

    // consumer never stalls
    assign pop = (count != '0);

    // storage, sender credits rule out overflow
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            pop_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (push_valid) begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
            count         <= count + cnt_w'(push_valid) - cnt_w'(pop);
            pop_valid     <= pop;
            credit_return <= pop;
        end
    end

endmodule

// File: src/branch_predict_unit.sv
/* top of the fetch-side branch prediction unit
   ties the pc generator, the btb predictor and the update queue together */
`timescale 1ns/1ns

module branch_predict_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    // resolved outcomes from execute
    input  logic                    update_valid,
    input  bp_pkg::bp_update_t      update,
    output logic                    update_credit,
    // misprediction override
    input  logic                    redirect_valid,
    input  logic [bp_pkg::xlen-1:0] redirect_pc,
    // requests toward instruction memory
    input  logic                    fetch_credit,
    output logic                    fetch_valid,
    output bp_pkg::fetch_req_t      fetch_req
);

    import bp_pkg::*;

    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] pred_next_pc;
    logic            upd_valid;
    bp_update_t      upd;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .pred_next_pc   (pred_next_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_credit   (fetch_credit),
        .pc             (fetch_pc),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req)
    );

    // prediction is combinational, lands in the same fetch_req
    two_bit_counter two_bit_counter_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc        (fetch_pc),
        .next_pc   (pred_next_pc),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    update_queue #(
        .payload_t (bp_update_t)
    ) update_queue_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .push_valid    (update_valid),
        .push_data     (update),
        .pop_valid     (upd_valid),
        .pop_data      (upd),
        .credit_return (update_credit)
    );

endmodule

// File: verif/tb_ref_model.svh
/* shadow btb, reference prediction and training rules, and the lcg for the bpu testbench
   included in the testbench module body after the package import */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int unsigned lcg_seed = 90;

// shadow table, one slot per word-address index
logic [xlen-1:0] sh_tag    [btb_entries];
logic [xlen-1:0] sh_target [btb_entries];
int              sh_cnt    [btb_entries];

// empty table, as after reset
function automatic void ref_reset();
    for (int i = 0; i < btb_entries; i++) begin
        sh_tag[i]    = invalid_tag;
        sh_target[i] = '0;
        sh_cnt[i]    = 0;
    end
endfunction

// word address modulo table size
function automatic int ref_index(input logic [xlen-1:0] pc);
    return int'((pc >> 2) % btb_entries);
endfunction

// taken only on a full tag hit with the counter in its upper half
function automatic logic [xlen-1:0] ref_predict(input logic [xlen-1:0] pc);
    int idx;
    idx = ref_index(pc);
    if (sh_tag[idx] == pc && sh_cnt[idx] >= 2) begin
        return sh_target[idx];
    end
    return pc + 4;
endfunction

function automatic void ref_update(input bp_update_t u);
    int idx;
    idx = ref_index(u.pc);
    if (!u.is_br) begin
        // not a branch, slot goes back to empty
        sh_tag[idx] = invalid_tag;
        sh_cnt[idx] = 0;
    end else begin
        sh_tag[idx] = u.pc;
        if (u.taken) begin
            sh_target[idx] = u.target;
            sh_cnt[idx]    = (sh_cnt[idx] == 3) ? 3 : sh_cnt[idx] + 1;
        end else begin
            sh_cnt[idx] = (sh_cnt[idx] == 0) ? 0 : sh_cnt[idx] - 1;
        end
    end
endfunction

// one lcg step, 32-bit wraparound
function automatic int unsigned lcg_step(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

// File: verif/tb_branch_predict_unit.sv
/* testbench for the branch prediction unit, models instruction memory and execute
   and compares every fetch request with the shadow btb */
`timescale 1ns/1ns

module tb_branch_predict_unit;

    import bp_pkg::*;

    `include "tb_ref_model.svh"

    // longest any single wait may run, in cycles
    localparam int wait_limit = 200;
    localparam logic [xlen-1:0] br_pc     = 32'h0000_2040;
    localparam logic [xlen-1:0] br_target = 32'h0000_3000;
    // same index as br_pc, other tag
    localparam logic [xlen-1:0] alias_pc  = 32'h0000_2140;
    localparam logic [xlen-1:0] far_pc    = 32'h0000_4000;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            update_valid;
    bp_update_t      update;
    logic            update_credit;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic            fetch_credit = 1'b0;
    logic            fetch_valid;
    fetch_req_t      fetch_req;

    // execute model
    int         exec_credits = update_depth;
    int         sent_total;
    int         credit_pulses;
    bp_update_t sent_q[$];
    // popped updates still on their way into the table
    bp_update_t stage1;
    bp_update_t stage2;
    logic       stage1_valid;
    logic       stage2_valid;

    // memory model
    logic        mem_return_en;
    int          outstanding;
    int          mem_delay;
    int unsigned mem_seed  = lcg_seed;
    int unsigned stim_seed = lcg_seed;
    int          fetch_count;
    fetch_req_t  req_log[$];
    // pc the generator should present next
    logic [xlen-1:0] exp_pc;

    always #5 clk = ~clk;

    branch_predict_unit branch_predict_unit_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .update_valid   (update_valid),
        .update         (update),
        .update_credit  (update_credit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_credit   (fetch_credit),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_fetch_req(input string name, input fetch_req_t got,
                                   input fetch_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s is pc %h next %h, expected pc %h next %h",
                               $time, name, got.pc, got.pred_next_pc, exp.pc, exp.pred_next_pc));
        end
    endtask

    task automatic check_credit_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    function automatic fetch_req_t expect_req(input logic [xlen-1:0] pc,
                                              input logic [xlen-1:0] next);
        fetch_req_t r;
        r.pc           = pc;
        r.pred_next_pc = next;
        return r;
    endfunction

    // scoreboard, outputs sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            // table write lands two edges after the credit pulse is seen
            if (stage2_valid) begin
                ref_update(stage2);
            end
            stage2_valid = stage1_valid;
            stage2       = stage1;
            stage1_valid = 1'b0;
            if (update_credit) begin
                credit_pulses++;
                exec_credits++;
                if (sent_q.size() != 0) begin
                    stage1       = sent_q.pop_front();
                    stage1_valid = 1'b1;
                end
            end
            if (fetch_valid) begin
                check_fetch_req("fetch_req", fetch_req,
                                expect_req(exp_pc, ref_predict(exp_pc)));
                fetch_count++;
                outstanding++;
                req_log.push_back(fetch_req);
            end
            // redirect first, then the prediction on a send, else the pc holds
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end else if (fetch_valid) begin
                exp_pc = ref_predict(exp_pc);
            end
        end
    end

    // memory returns one credit per request after a random gap
    always @(posedge clk) begin
        if (!arst_n || !mem_return_en || outstanding == 0) begin
            fetch_credit <= 1'b0;
        end else if (mem_delay > 0) begin
            fetch_credit <= 1'b0;
            mem_delay--;
        end else begin
            fetch_credit <= 1'b1;
            outstanding--;
            mem_seed  = lcg_step(mem_seed);
            mem_delay = int'((mem_seed >> 16) % 4);
        end
    end

    // execute sends only while it holds a credit
    task automatic send_update(input logic [xlen-1:0] pc, input logic is_br, input logic taken,
                               input logic [xlen-1:0] target);
        bp_update_t u;
        int         waited;
        u.pc     = pc;
        u.is_br  = is_br;
        u.taken  = taken;
        u.target = target;
        waited   = 0;
        @(posedge clk);
        update_valid <= 1'b0;
        while (exec_credits == 0) begin
            if (waited == wait_limit) begin
                fail_run("execute never got an update credit back");
            end
            waited++;
            @(posedge clk);
        end
        update_valid <= 1'b1;
        update       <= u;
        exec_credits--;
        sent_total++;
        sent_q.push_back(u);
    endtask

    // every sent update credited and written into the table
    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge clk);
        update_valid <= 1'b0;
        while (sent_q.size() != 0 || stage1_valid || stage2_valid) begin
            if (waited == wait_limit) begin
                fail_run("sent updates did not all come back as credits");
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic redirect_to(input logic [xlen-1:0] pc);
        @(posedge clk);
        update_valid   <= 1'b0;
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic wait_fetch_at(input logic [xlen-1:0] pc);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(fetch_valid && fetch_req.pc == pc)) begin
            if (waited == wait_limit) begin
                fail_run($sformatf("no fetch request was issued at pc %h", pc));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic lookup_check(input logic [xlen-1:0] pc, input logic [xlen-1:0] next);
        redirect_to(pc);
        wait_fetch_at(pc);
        check_fetch_req("fetch_req", fetch_req, expect_req(pc, next));
    endtask

    initial begin
        logic [31:0]     rnd;
        logic [xlen-1:0] upd_pc;
        int              waited;

        arst_n         = 1'b0;
        update_valid   = 1'b0;
        update         = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        mem_return_en  = 1'b0;
        stage1         = '0;
        stage2         = '0;
        stage1_valid   = 1'b0;
        stage2_valid   = 1'b0;
        exp_pc         = reset_pc;
        ref_reset();

        // outputs quiet while reset is held and right after release
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("fetch_valid", fetch_valid, 1'b0);
        check_flag("update_credit", update_credit, 1'b0);
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("fetch_valid", fetch_valid, 1'b0);
        check_flag("update_credit", update_credit, 1'b0);
        wait_fetch_at(reset_pc);
        check_fetch_req("fetch_req", fetch_req, expect_req(reset_pc, reset_pc + 4));

        // memory holds its credits, so the generator stalls
        waited = 0;
        @(posedge clk);
        while (fetch_count < fetch_credits) begin
            if (waited == wait_limit) begin
                fail_run("fetch requests stopped before the credits ran out");
            end
            waited++;
            @(posedge clk);
        end
        repeat (6) begin
            @(negedge clk);
            check_flag("fetch_valid", fetch_valid, 1'b0);
            check_fetch_req("fetch_req", fetch_req, expect_req(reset_pc + 4 * fetch_credits,
                                                               reset_pc + 4 * fetch_credits + 4));
        end
        @(posedge clk);
        check_credit_count("fetch requests", fetch_count, fetch_credits);
        for (int i = 0; i < fetch_credits; i++) begin
            check_fetch_req("fetch_req", req_log[i],
                            expect_req(reset_pc + 4 * i, reset_pc + 4 * i + 4));
        end
        mem_return_en <= 1'b1;

        // two taken outcomes reach weakly taken
        repeat (2) begin
            send_update(br_pc, 1'b1, 1'b1, br_target);
        end
        wait_drained();
        lookup_check(br_pc, br_target);
        // saturates at strongly not taken
        repeat (3) begin
            send_update(br_pc, 1'b1, 1'b0, 32'h0);
        end
        wait_drained();
        lookup_check(br_pc, br_pc + 4);

        // retrain, then a non-branch outcome drops the slot
        repeat (2) begin
            send_update(br_pc, 1'b1, 1'b1, br_target);
        end
        wait_drained();
        lookup_check(br_pc, br_target);
        send_update(br_pc, 1'b0, 1'b0, 32'h0);
        wait_drained();
        lookup_check(br_pc, br_pc + 4);
        // same slot, other tag
        repeat (2) begin
            send_update(br_pc, 1'b1, 1'b1, br_target);
        end
        wait_drained();
        lookup_check(alias_pc, alias_pc + 4);
        lookup_check(br_pc, br_target);

        // random outcomes on 32 words and their aliases, redirects into the same range
        for (int n = 0; n < 60; n++) begin
            stim_seed = lcg_step(stim_seed);
            rnd       = stim_seed;
            upd_pc    = 32'h0000_2000 + {rnd[12:8], 2'b00} + {rnd[13], 8'h00};
            if (rnd[15:14] == 2'b00) begin
                redirect_to(32'h0000_2000 + {rnd[20:16], 2'b00});
            end
            send_update(upd_pc, rnd[23:22] != 2'b00, rnd[24],
                        32'h0000_2000 + {rnd[30:25], 2'b00});
        end
        wait_drained();
        repeat (4) @(posedge clk);
        check_credit_count("update_credit pulses", credit_pulses, sent_total);

        // redirect lands while br_pc has its taken target pending
        repeat (2) begin
            send_update(br_pc, 1'b1, 1'b1, br_target);
        end
        wait_drained();
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= br_pc;
        @(posedge clk);
        redirect_pc    <= far_pc;
        @(negedge clk);
        check_fetch_req("fetch_req", fetch_req, expect_req(br_pc, br_target));
        @(posedge clk);
        redirect_valid <= 1'b0;
        wait_fetch_at(far_pc);
        check_fetch_req("fetch_req", fetch_req, expect_req(far_pc, far_pc + 4));

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: branch_predict_unit.f
+incdir+verif
common/bp_pkg.sv
src/predictor/two_bit_counter.sv
src/fetch_pc_gen.sv
src/update_queue.sv
src/branch_predict_unit.sv
verif/tb_branch_predict_unit.sv

// File: Bender.yml
package:
  name: branch_predict_unit

sources:
  - common/bp_pkg.sv
  - src/predictor/two_bit_counter.sv
  - src/fetch_pc_gen.sv
  - src/update_queue.sv
  - src/branch_predict_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_branch_predict_unit.sv
